/* Bender.yml */
package:
  name: memory_bus

sources:
  - files:
      - hdl/bus_pkg.sv
      - hdl/bus_address_decode.sv
      - hdl/ram_access_unit.sv
      - hdl/platform_regs.sv
      - hdl/bus_response.sv
      - hdl/memory_bus_top.sv
  - target: test
    files:
      - verification/memory_bus_assertions.sv
      - verification/memory_bus_tb.sv

/* hdl/bus_address_decode.sv */
`default_nettype none

module bus_address_decode (
    input  wire bus_pkg::bus_req_t req,
    output bus_pkg::bus_sel_t      sel
);

    // byte offset into the priority window
    logic [bus_pkg::ADDR_W-1:0] prio_off;

    assign prio_off = req.addr - bus_pkg::PLIC_BASE;

    always_comb begin
        // unmapped unless a match below
        sel.region = bus_pkg::REG_NONE;
        sel.ctx = 1'b0;
        sel.src_id = '0;

        if (req.addr >= bus_pkg::RAM_BASE &&
            req.addr < bus_pkg::RAM_BASE + bus_pkg::RAM_BYTES) begin
            sel.region = bus_pkg::REG_RAM;
        end else if (req.addr == bus_pkg::MTIME_ADDR) begin
            sel.region = bus_pkg::REG_MTIME;
        end else if (req.addr == bus_pkg::MTIMECMP_ADDR) begin
            sel.region = bus_pkg::REG_MTIMECMP;
        end else if (req.addr >= bus_pkg::PLIC_BASE && req.addr < bus_pkg::PLIC_PRIO_END) begin
            // one 4-byte slot per source id
            sel.region = bus_pkg::REG_PRIO;
            sel.src_id = prio_off[bus_pkg::SRC_W+1:2];
        end else if (req.addr == bus_pkg::PLIC_PENDING) begin
            sel.region = bus_pkg::REG_PENDING;
        end else if (req.addr == bus_pkg::PLIC_ENABLE) begin
            sel.region = bus_pkg::REG_ENABLE;
        end else if (req.addr == bus_pkg::PLIC_ENABLE + bus_pkg::ENABLE_CTX_STRIDE) begin
            sel.region = bus_pkg::REG_ENABLE;
            sel.ctx = 1'b1;
        end else if (req.addr == bus_pkg::PLIC_THRESHOLD) begin
            sel.region = bus_pkg::REG_THRESHOLD;
        end else if (req.addr == bus_pkg::PLIC_THRESHOLD + bus_pkg::CTX_STRIDE) begin
            sel.region = bus_pkg::REG_THRESHOLD;
            sel.ctx = 1'b1;
        end else if (req.addr == bus_pkg::PLIC_CLAIM) begin
            sel.region = bus_pkg::REG_CLAIM;
        end else if (req.addr == bus_pkg::PLIC_CLAIM + bus_pkg::CTX_STRIDE) begin
            // context 1 claim sits one context stride up
            sel.region = bus_pkg::REG_CLAIM;
            sel.ctx = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* hdl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    // bus widths
    localparam int DATA_W = 64;
    localparam int ADDR_W = 64;

    // on-chip data RAM, 32-bit words
    localparam int RAM_WORDS = 512;
    localparam int RAM_IDX_W = $clog2(RAM_WORDS);
    localparam logic [ADDR_W-1:0] RAM_BASE = 64'h0000_0000_8000_0000;
    localparam logic [ADDR_W-1:0] RAM_BYTES = 64'(RAM_WORDS * 4);

    // machine timer
    localparam logic [ADDR_W-1:0] MTIME_ADDR = 64'h0000_0000_0200_BFF8;
    localparam logic [ADDR_W-1:0] MTIMECMP_ADDR = 64'h0000_0000_0200_4000;
    localparam logic [DATA_W-1:0] MTIMECMP_RESET = 64'h0000_0000_8000_0000;

    // interrupt controller map
    localparam int PLIC_SOURCES = 6;
    localparam int SRC_W = 3;
    localparam int PRIO_W = 3;
    localparam logic [SRC_W-1:0] IRQ_ID = 3'd1;
    localparam logic [ADDR_W-1:0] PLIC_BASE = 64'h0000_0000_0C00_0000;
    // priority window ends after the last source id
    localparam logic [ADDR_W-1:0] PLIC_PRIO_END = PLIC_BASE + 64'(PLIC_SOURCES * 4);
    localparam logic [ADDR_W-1:0] PLIC_PENDING = PLIC_BASE + 64'h1000;
    localparam logic [ADDR_W-1:0] PLIC_ENABLE = PLIC_BASE + 64'h2000;
    localparam logic [ADDR_W-1:0] ENABLE_CTX_STRIDE = 64'h80;
    localparam logic [ADDR_W-1:0] PLIC_THRESHOLD = PLIC_BASE + 64'h20_0000;
    localparam logic [ADDR_W-1:0] PLIC_CLAIM = PLIC_THRESHOLD + 64'h4;
    localparam logic [ADDR_W-1:0] CTX_STRIDE = 64'h1000;

    // access size, same encoding as the core's funct3
    typedef enum logic [2:0] {
        LS_B  = 3'b000,
        LS_H  = 3'b001,
        LS_W  = 3'b010,
        LS_D  = 3'b011,
        LS_BU = 3'b100,
        LS_HU = 3'b101,
        LS_WU = 3'b110
    } ls_type_e;

    // decoded target of a request
    typedef enum logic [3:0] {
        REG_NONE,
        REG_RAM,
        REG_MTIME,
        REG_MTIMECMP,
        REG_PRIO,
        REG_PENDING,
        REG_ENABLE,
        REG_THRESHOLD,
        REG_CLAIM
    } region_e;

    // request held stable by the core until done
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        ls_type_e          ls_type;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        region_e          region;
        logic             ctx;
        logic [SRC_W-1:0] src_id;
    } bus_sel_t;

    typedef struct packed {
        logic rd;
        logic wr;
    } bus_active_t;

    // one response per execute unit
    typedef struct packed {
        logic              finish;
        logic [DATA_W-1:0] data;
    } unit_rsp_t;

endpackage

`default_nettype wire

/* hdl/bus_response.sv */
`default_nettype none

module bus_response (
    input  wire                       clock_slow,
    input  wire                       KEY0,
    input  wire                       rd_en,
    input  wire                       wr_en,
    input  wire bus_pkg::bus_sel_t    sel,
    input  wire bus_pkg::unit_rsp_t   ram_rsp,
    input  wire bus_pkg::unit_rsp_t   plat_rsp,
    output bus_pkg::bus_active_t      active,
    output logic [bus_pkg::DATA_W-1:0] rdata,
    output logic                      read_done,
    output logic                      write_done
);

    logic                       complete;
    logic [bus_pkg::DATA_W-1:0] rsp_data;

    // idle units drive zero, so an OR merges them
    assign rsp_data = ram_rsp.data | plat_rsp.data;
    // unmapped access ends at once with zero data
    assign complete = ram_rsp.finish || plat_rsp.finish ||
                      (sel.region == bus_pkg::REG_NONE);

    // done levels and active flags
    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            read_done <= 1'b1;
            write_done <= 1'b1;
            active <= '0;
        end else begin
            if (rd_en) begin
                read_done <= 1'b0;
                active.rd <= 1'b1;
            end else if (active.rd && complete) begin
                read_done <= 1'b1;
                active.rd <= 1'b0;
            end
            if (wr_en) begin
                write_done <= 1'b0;
                active.wr <= 1'b1;
            end else if (active.wr && complete) begin
                write_done <= 1'b1;
                active.wr <= 1'b0;
            end
        end
    end

    // read data, held until the next read finishes
    always_ff @(posedge clock_slow) begin
        if (active.rd && complete) begin
            rdata <= rsp_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/memory_bus_top.sv */
`default_nettype none

module memory_bus_top (
    input  wire                        clock_slow,
    input  wire                        KEY0,
    input  wire                        rd_en,
    input  wire                        wr_en,
    input  wire bus_pkg::bus_req_t     req,
    input  wire [bus_pkg::DATA_W-1:0]  mtime,
    input  wire                        irq_source,
    output logic [bus_pkg::DATA_W-1:0] rdata,
    output logic                       read_done,
    output logic                       write_done,
    output logic                       meip,
    output logic                       msip
);

    bus_pkg::bus_sel_t    sel;
    bus_pkg::bus_active_t active;
    bus_pkg::unit_rsp_t   ram_rsp;
    bus_pkg::unit_rsp_t   plat_rsp;

    // decode
    bus_address_decode u_decode (
        .req (req),
        .sel (sel)
    );

    // execute: data RAM
    ram_access_unit u_ram (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .req        (req),
        .sel        (sel),
        .active     (active),
        .rsp        (ram_rsp)
    );

    // execute: timer and interrupt controller
    platform_regs u_plat (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .req        (req),
        .sel        (sel),
        .active     (active),
        .mtime      (mtime),
        .irq_source (irq_source),
        .rsp        (plat_rsp),
        .meip       (meip),
        .msip       (msip)
    );

    // result
    bus_response u_resp (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .sel        (sel),
        .ram_rsp    (ram_rsp),
        .plat_rsp   (plat_rsp),
        .active     (active),
        .rdata      (rdata),
        .read_done  (read_done),
        .write_done (write_done)
    );

endmodule

`default_nettype wire

/* hdl/platform_regs.sv */
`default_nettype none

module platform_regs (
    input  wire                             clock_slow,
    input  wire                             KEY0,
    input  wire bus_pkg::bus_req_t          req,
    input  wire bus_pkg::bus_sel_t          sel,
    input  wire bus_pkg::bus_active_t       active,
    input  wire [bus_pkg::DATA_W-1:0]       mtime,
    input  wire                             irq_source,
    output bus_pkg::unit_rsp_t              rsp,
    output logic                            meip,
    output logic                            msip
);

    logic [bus_pkg::DATA_W-1:0]       mtimecmp;
    logic [bus_pkg::PRIO_W-1:0]       prio [0:bus_pkg::PLIC_SOURCES-1];
    logic [bus_pkg::PLIC_SOURCES-1:0] pending;
    logic [bus_pkg::PLIC_SOURCES-1:0] enable [0:1];
    logic [bus_pkg::PRIO_W-1:0]       threshold [0:1];
    logic [bus_pkg::SRC_W-1:0]        claim_id [0:1];
    logic                             irq_prev;
    logic                             irq_rise;
    logic                             hit;
    logic [bus_pkg::DATA_W-1:0]       rd_data;

    // everything except RAM and unmapped lands here
    assign hit = (active.rd || active.wr) &&
                 (sel.region != bus_pkg::REG_NONE) && (sel.region != bus_pkg::REG_RAM);
    assign irq_rise = irq_source && !irq_prev;

    // claim id per context, priority and threshold not involved
    always_comb begin
        for (int c = 0; c < 2; c++) begin
            claim_id[c] = '0;
            if (pending[bus_pkg::IRQ_ID] && enable[c][bus_pkg::IRQ_ID]) begin
                claim_id[c] = bus_pkg::IRQ_ID;
            end
        end
    end

    assign meip = (claim_id[0] != '0);
    assign msip = (claim_id[1] != '0);

    // read mux, zero-extended
    always_comb begin
        rd_data = '0;
        case (sel.region)
            bus_pkg::REG_MTIME:     rd_data = mtime;
            bus_pkg::REG_MTIMECMP:  rd_data = mtimecmp;
            bus_pkg::REG_PRIO:      rd_data[bus_pkg::PRIO_W-1:0] = prio[sel.src_id];
            bus_pkg::REG_PENDING:   rd_data[bus_pkg::PLIC_SOURCES-1:0] = pending;
            bus_pkg::REG_ENABLE:    rd_data[bus_pkg::PLIC_SOURCES-1:0] = enable[sel.ctx];
            bus_pkg::REG_THRESHOLD: rd_data[bus_pkg::PRIO_W-1:0] = threshold[sel.ctx];
            bus_pkg::REG_CLAIM:     rd_data[bus_pkg::SRC_W-1:0] = claim_id[sel.ctx];
            default:                rd_data = '0;
        endcase
    end

    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            mtimecmp <= bus_pkg::MTIMECMP_RESET;
            pending <= '0;
            irq_prev <= 1'b0;
            for (int i = 0; i < bus_pkg::PLIC_SOURCES; i++) begin
                prio[i] <= '0;
            end
            for (int c = 0; c < 2; c++) begin
                enable[c] <= '0;
                threshold[c] <= '0;
            end
        end else begin
            irq_prev <= irq_source;
            if (hit && active.wr) begin
                // pending, mtime and claim writes are dropped
                case (sel.region)
                    bus_pkg::REG_MTIMECMP:  mtimecmp <= req.wdata;
                    bus_pkg::REG_PRIO:      prio[sel.src_id] <= req.wdata[bus_pkg::PRIO_W-1:0];
                    bus_pkg::REG_ENABLE:
                        enable[sel.ctx] <= req.wdata[bus_pkg::PLIC_SOURCES-1:0];
                    bus_pkg::REG_THRESHOLD: threshold[sel.ctx] <= req.wdata[bus_pkg::PRIO_W-1:0];
                    default: ;
                endcase
            end
            // claim read retires the source
            if (hit && active.rd && sel.region == bus_pkg::REG_CLAIM && claim_id[sel.ctx] != '0) begin
                pending[bus_pkg::IRQ_ID] <= 1'b0;
            end
            // a new edge wins over a claim in the same cycle
            if (irq_rise) begin
                pending[bus_pkg::IRQ_ID] <= 1'b1;
            end
        end
    end

    // every register access takes one cycle
    assign rsp.finish = hit;
    assign rsp.data = (hit && active.rd) ? rd_data : '0;

endmodule

`default_nettype wire

/* hdl/ram_access_unit.sv */
`default_nettype none

module ram_access_unit (
    input  wire                       clock_slow,
    input  wire                       KEY0,
    input  wire bus_pkg::bus_req_t    req,
    input  wire bus_pkg::bus_sel_t    sel,
    input  wire bus_pkg::bus_active_t active,
    output bus_pkg::unit_rsp_t        rsp
);

    // data RAM, one 32-bit word per entry
    logic [31:0] mem [0:bus_pkg::RAM_WORDS-1];

    // second beat of a doubleword
    logic beat;
    // low word of a doubleword load
    logic [31:0] low_word;

    logic                          hit;
    logic                          is_d;
    logic [1:0]                    byte_off;
    logic [bus_pkg::RAM_IDX_W-1:0] word_idx;
    logic [bus_pkg::RAM_IDX_W-1:0] next_idx;
    logic [bus_pkg::RAM_IDX_W-1:0] acc_idx;
    logic [31:0]                   rd_word;
    logic [31:0]                   wr_word;
    logic [3:0]                    wr_mask;
    logic [bus_pkg::DATA_W-1:0]    load_data;

    assign hit = (active.rd || active.wr) && (sel.region == bus_pkg::REG_RAM);
    assign is_d = (req.ls_type == bus_pkg::LS_D);
    assign byte_off = req.addr[1:0];
    // base is aligned, so the low address bits index the array
    assign word_idx = req.addr[bus_pkg::RAM_IDX_W+1:2];
    assign next_idx = word_idx + 1'b1;
    // beat 1 moves to the following word
    assign acc_idx = beat ? next_idx : word_idx;
    assign rd_word = mem[acc_idx];

    // load path
    always_comb begin
        if (is_d) begin
            load_data = {rd_word, low_word};
        end else begin
            // zero-filled, the core sign-extends
            load_data = {32'b0, rd_word >> {byte_off, 3'b000}};
        end
    end

    // byte lanes for stores
    always_comb begin
        wr_mask = 4'b0000;
        wr_word = req.wdata[31:0] << {byte_off, 3'b000};
        case (req.ls_type)
            bus_pkg::LS_B, bus_pkg::LS_BU: begin
                wr_mask = 4'b0001 << byte_off;
            end
            bus_pkg::LS_H, bus_pkg::LS_HU: begin
                // odd halfword offset writes nothing
                if (!byte_off[0]) begin
                    wr_mask = 4'b0011 << byte_off;
                end
            end
            bus_pkg::LS_W, bus_pkg::LS_WU: begin
                wr_mask = 4'b1111;
                wr_word = req.wdata[31:0];
            end
            bus_pkg::LS_D: begin
                wr_mask = 4'b1111;
                wr_word = beat ? req.wdata[63:32] : req.wdata[31:0];
            end
            default: begin
                wr_mask = 4'b0000;
            end
        endcase
    end

    // beat counter, toggles only through a doubleword
    always_ff @(posedge clock_slow or negedge KEY0) begin
        if (!KEY0) begin
            beat <= 1'b0;
        end else if (hit && is_d) begin
            beat <= ~beat;
        end else begin
            beat <= 1'b0;
        end
    end

    always_ff @(posedge clock_slow) begin
        if (hit && active.wr) begin
            for (int b = 0; b < 4; b++) begin
                if (wr_mask[b]) begin
                    mem[acc_idx][8*b +: 8] <= wr_word[8*b +: 8];
                end
            end
        end
        // hold first word until beat 1
        if (hit && active.rd && is_d && !beat) begin
            low_word <= rd_word;
        end
    end

    // done on the only beat, or beat 1 of a doubleword
    assign rsp.finish = hit && (!is_d || beat);
    assign rsp.data = (rsp.finish && active.rd) ? load_data : '0;

endmodule

`default_nettype wire

/* memory_bus_top.f */
hdl/bus_pkg.sv
hdl/bus_address_decode.sv
hdl/ram_access_unit.sv
hdl/platform_regs.sv
hdl/bus_response.sv
hdl/memory_bus_top.sv
verification/memory_bus_assertions.sv
verification/memory_bus_tb.sv

/* verification/memory_bus_assertions.sv */
`default_nettype none

module memory_bus_assertions (
    input wire clock_slow,
    input wire KEY0,
    input wire rd_en,
    input wire wr_en,
    input wire read_done,
    input wire write_done,
    input wire irq_source,
    input wire irq_pending
);

    // raised when any property below fails
    logic failed = 1'b0;

    // strobes only while idle
    assert property (@(posedge clock_slow) disable iff (!KEY0) rd_en |-> read_done)
        else begin
            $error("read strobe while read_done low");
            failed = 1'b1;
        end
    assert property (@(posedge clock_slow) disable iff (!KEY0) wr_en |-> write_done)
        else begin
            $error("write strobe while write_done low");
            failed = 1'b1;
        end

    // one beat or two for a doubleword
    assert property (@(posedge clock_slow) disable iff (!KEY0)
                     $fell(read_done) |-> ##[1:2] read_done)
        else begin
            $error("read_done low for more than 2 cycles");
            failed = 1'b1;
        end
    assert property (@(posedge clock_slow) disable iff (!KEY0)
                     $fell(write_done) |-> ##[1:2] write_done)
        else begin
            $error("write_done low for more than 2 cycles");
            failed = 1'b1;
        end

    // pending only rises one edge after a 0-to-1 change of the source
    assert property (@(posedge clock_slow) disable iff (!KEY0)
                     $rose(irq_pending) |-> $past(irq_source) && !$past(irq_source, 2))
        else begin
            $error("pending bit rose without a source edge");
            failed = 1'b1;
        end

endmodule

bind bus_response memory_bus_assertions u_bus_checks (
    .clock_slow  (clock_slow),
    .KEY0        (KEY0),
    .rd_en       (rd_en),
    .wr_en       (wr_en),
    .read_done   (read_done),
    .write_done  (write_done),
    .irq_source  (1'b0),
    .irq_pending (1'b0)
);

bind platform_regs memory_bus_assertions u_irq_checks (
    .clock_slow  (clock_slow),
    .KEY0        (KEY0),
    .rd_en       (1'b0),
    .wr_en       (1'b0),
    .read_done   (1'b1),
    .write_done  (1'b1),
    .irq_source  (irq_source),
    .irq_pending (pending[bus_pkg::IRQ_ID])
);

`default_nettype wire

/* verification/memory_bus_tb.sv */
`default_nettype none

module memory_bus_tb;

    // RAM words touched by the test from RAM_BASE up
    localparam int RAM_WIN = 16;
    localparam int N_ACCESS = 110;
    localparam int TIMEOUT_CYCLES = N_ACCESS * 10 + 200;
    localparam logic [63:0] UNMAPPED_ADDR = 64'h0000_0000_4000_0000;

    logic                       clock_slow;
    logic                       KEY0;
    logic                       rd_en;
    logic                       wr_en;
    bus_pkg::bus_req_t          req;
    logic [bus_pkg::DATA_W-1:0] mtime;
    logic                       irq_source;
    logic [bus_pkg::DATA_W-1:0] rdata;
    logic                       read_done;
    logic                       write_done;
    logic                       meip;
    logic                       msip;

    // reference model state
    logic [31:0]                      ram_model [0:RAM_WIN-1];
    logic [63:0]                      mtimecmp_m;
    logic [bus_pkg::PRIO_W-1:0]       prio_m [0:bus_pkg::PLIC_SOURCES-1];
    logic [bus_pkg::PLIC_SOURCES-1:0] pending_m;
    logic [bus_pkg::PLIC_SOURCES-1:0] enable_m [0:1];
    logic [bus_pkg::PRIO_W-1:0]       threshold_m [0:1];
    // expected read data with the oldest first
    logic [bus_pkg::DATA_W-1:0]       exp_q [$];
    int                               err_count;

    memory_bus_top UUT (
        .clock_slow (clock_slow),
        .KEY0       (KEY0),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .req        (req),
        .mtime      (mtime),
        .irq_source (irq_source),
        .rdata      (rdata),
        .read_done  (read_done),
        .write_done (write_done),
        .meip       (meip),
        .msip       (msip)
    );

    initial begin
        clock_slow = 1'b0;
        forever #10 clock_slow = ~clock_slow;
    end

    task automatic fail_run(input string msg);
        err_count++;
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_data(input string name, input logic [bus_pkg::DATA_W-1:0] got,
                              input logic [bus_pkg::DATA_W-1:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic in_ram(input logic [63:0] addr);
        return addr >= bus_pkg::RAM_BASE && addr < bus_pkg::RAM_BASE + 64'(RAM_WIN * 4);
    endfunction

    // claim id when the source is pending and enabled for the context
    function automatic logic [bus_pkg::SRC_W-1:0] model_claim(input int ctx);
        if (pending_m[bus_pkg::IRQ_ID] && enable_m[ctx][bus_pkg::IRQ_ID]) begin
            return bus_pkg::IRQ_ID;
        end
        return '0;
    endfunction

    // expected read data from the model
    function automatic logic [63:0] expected_read(input logic [63:0] addr,
                                                  input bus_pkg::ls_type_e ls);
        int idx;
        int off;
        int pid;
        idx = int'((addr - bus_pkg::RAM_BASE) >> 2);
        off = int'(addr[1:0]);
        pid = int'((addr - bus_pkg::PLIC_BASE) >> 2);
        if (in_ram(addr)) begin
            // doubleword takes the addressed word low and the next word high
            if (ls == bus_pkg::LS_D) begin
                return {ram_model[idx + 1], ram_model[idx]};
            end
            return {32'b0, ram_model[idx] >> (8 * off)};
        end
        if (addr == bus_pkg::MTIME_ADDR) return mtime;
        if (addr == bus_pkg::MTIMECMP_ADDR) return mtimecmp_m;
        if (addr >= bus_pkg::PLIC_BASE &&
            addr < bus_pkg::PLIC_BASE + 64'(bus_pkg::PLIC_SOURCES * 4)) begin
            return 64'(prio_m[pid]);
        end
        if (addr == bus_pkg::PLIC_PENDING) return 64'(pending_m);
        for (int c = 0; c < 2; c++) begin
            if (addr == bus_pkg::PLIC_ENABLE + c * bus_pkg::ENABLE_CTX_STRIDE) begin
                return 64'(enable_m[c]);
            end
            if (addr == bus_pkg::PLIC_THRESHOLD + c * bus_pkg::CTX_STRIDE) begin
                return 64'(threshold_m[c]);
            end
            if (addr == bus_pkg::PLIC_CLAIM + c * bus_pkg::CTX_STRIDE) begin
                return 64'(model_claim(c));
            end
        end
        // unmapped reads as zero
        return '0;
    endfunction

    task automatic model_store(input logic [63:0] addr, input bus_pkg::ls_type_e ls,
                               input logic [63:0] wdata);
        int idx;
        int off;
        int pid;
        idx = int'((addr - bus_pkg::RAM_BASE) >> 2);
        off = int'(addr[1:0]);
        pid = int'((addr - bus_pkg::PLIC_BASE) >> 2);
        if (in_ram(addr)) begin
            case (ls)
                bus_pkg::LS_B, bus_pkg::LS_BU: ram_model[idx][8*off +: 8] = wdata[7:0];
                bus_pkg::LS_H, bus_pkg::LS_HU: begin
                    // odd halfword leaves memory alone
                    if (off % 2 == 0) ram_model[idx][8*off +: 16] = wdata[15:0];
                end
                bus_pkg::LS_D: begin
                    ram_model[idx] = wdata[31:0];
                    ram_model[idx + 1] = wdata[63:32];
                end
                default: ram_model[idx] = wdata[31:0];
            endcase
        end else if (addr == bus_pkg::MTIMECMP_ADDR) begin
            mtimecmp_m = wdata;
        end else if (addr >= bus_pkg::PLIC_BASE &&
                     addr < bus_pkg::PLIC_BASE + 64'(bus_pkg::PLIC_SOURCES * 4)) begin
            prio_m[pid] = wdata[bus_pkg::PRIO_W-1:0];
        end else begin
            for (int c = 0; c < 2; c++) begin
                if (addr == bus_pkg::PLIC_ENABLE + c * bus_pkg::ENABLE_CTX_STRIDE) begin
                    enable_m[c] = wdata[bus_pkg::PLIC_SOURCES-1:0];
                end
                if (addr == bus_pkg::PLIC_THRESHOLD + c * bus_pkg::CTX_STRIDE) begin
                    threshold_m[c] = wdata[bus_pkg::PRIO_W-1:0];
                end
            end
        end
    endtask

    // one strobe then a wait for the done level
    task automatic bus_access(input logic is_read, input logic [63:0] addr,
                              input bus_pkg::ls_type_e ls, input logic [63:0] wdata);
        int          n;
        int          exp_n;
        logic        done_now;
        logic [63:0] exp;
        string       done_name;
        n = 0;
        exp_n = (ls == bus_pkg::LS_D && in_ram(addr)) ? 2 : 1;
        done_name = is_read ? "read_done" : "write_done";
        @(negedge clock_slow);
        req.addr = addr;
        req.ls_type = ls;
        req.wdata = wdata;
        if (is_read) begin
            exp = expected_read(addr, ls);
            exp_q.push_back(exp);
            // a nonzero claim retires the source
            if ((addr == bus_pkg::PLIC_CLAIM || addr == bus_pkg::PLIC_CLAIM + bus_pkg::CTX_STRIDE)
                && exp != '0) begin
                pending_m[bus_pkg::IRQ_ID] = 1'b0;
            end
            rd_en = 1'b1;
        end else begin
            model_store(addr, ls, wdata);
            wr_en = 1'b1;
        end
        do begin
            @(negedge clock_slow);
            rd_en = 1'b0;
            wr_en = 1'b0;
            done_now = is_read ? read_done : write_done;
            if (!done_now) n++;
        end while (!done_now && n <= 10);
        if (n != exp_n) begin
            fail_run($sformatf("%s stayed low for %0d cycles at address 0x%h, expected %0d",
                               done_name, n, addr, exp_n));
        end
    endtask

    task automatic bus_read(input logic [63:0] addr, input bus_pkg::ls_type_e ls);
        bus_access(1'b1, addr, ls, '0);
    endtask

    task automatic bus_write(input logic [63:0] addr, input bus_pkg::ls_type_e ls,
                             input logic [63:0] wdata);
        bus_access(1'b0, addr, ls, wdata);
    endtask

    // one-cycle high pulse sets pending on the next edge
    task automatic pulse_irq();
        @(negedge clock_slow);
        irq_source = 1'b1;
        @(negedge clock_slow);
        irq_source = 1'b0;
        pending_m[bus_pkg::IRQ_ID] = 1'b1;
    endtask

    task automatic check_irq_lines();
        check_flag("meip", meip, model_claim(0) != '0);
        check_flag("msip", msip, model_claim(1) != '0);
    endtask

    // compare each finished read with the model
    initial begin
        logic [bus_pkg::DATA_W-1:0] exp;
        @(posedge KEY0);
        forever begin
            @(posedge read_done);
            @(negedge clock_slow);
            if (exp_q.size() == 0) begin
                fail_run("read_done rose with no read outstanding");
            end else begin
                exp = exp_q.pop_front();
                check_data("rdata", rdata, exp);
            end
        end
    end

    // bound checkers raise a flag when a property fails
    initial begin
        wait (UUT.u_resp.u_bus_checks.failed === 1'b1 ||
              UUT.u_plat.u_irq_checks.failed === 1'b1);
        fail_run("a bound protocol assertion failed");
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock_slow);
        $display("watchdog expired after %0d cycles, a bus access never completed",
                 TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        bus_pkg::ls_type_e ls;
        int                idx;
        int                off;
        logic [63:0]       wd;
        void'($urandom(47));
        KEY0 = 1'b0;
        rd_en = 1'b0;
        wr_en = 1'b0;
        req = '0;
        mtime = '0;
        irq_source = 1'b0;
        err_count = 0;
        mtimecmp_m = bus_pkg::MTIMECMP_RESET;
        pending_m = '0;
        for (int i = 0; i < bus_pkg::PLIC_SOURCES; i++) prio_m[i] = '0;
        for (int c = 0; c < 2; c++) begin
            enable_m[c] = '0;
            threshold_m[c] = '0;
        end
        repeat (4) @(negedge clock_slow);
        KEY0 = 1'b1;
        mtime = {$urandom, $urandom};

        // reset values
        @(negedge clock_slow);
        check_flag("read_done", read_done, 1'b1);
        check_flag("write_done", write_done, 1'b1);
        check_irq_lines();
        bus_read(bus_pkg::MTIMECMP_ADDR, bus_pkg::LS_D);

        // fill the window before mixed stores and loads
        for (int i = 0; i < RAM_WIN; i++) begin
            bus_write(bus_pkg::RAM_BASE + 64'(4 * i), bus_pkg::LS_W, {$urandom, $urandom});
        end
        for (int n = 0; n < 28; n++) begin
            case (n % 4)
                0: ls = bus_pkg::LS_B;
                1: ls = bus_pkg::LS_H;
                2: ls = bus_pkg::LS_W;
                default: ls = bus_pkg::LS_D;
            endcase
            idx = $urandom_range(RAM_WIN - 2, 0);
            off = (ls == bus_pkg::LS_W || ls == bus_pkg::LS_D) ? 0 : $urandom_range(3, 0);
            bus_write(bus_pkg::RAM_BASE + 64'(4 * idx + off), ls, {$urandom, $urandom});
        end
        for (int n = 0; n < 28; n++) begin
            // funct3 order covers every load type
            ls = bus_pkg::ls_type_e'(n % 7);
            idx = $urandom_range(RAM_WIN - 2, 0);
            off = (ls == bus_pkg::LS_D) ? 0 : $urandom_range(3, 0);
            bus_read(bus_pkg::RAM_BASE + 64'(4 * idx + off), ls);
        end

        // timer
        wd = {$urandom, $urandom};
        bus_write(bus_pkg::MTIMECMP_ADDR, bus_pkg::LS_D, wd);
        bus_read(bus_pkg::MTIMECMP_ADDR, bus_pkg::LS_D);
        bus_read(bus_pkg::MTIME_ADDR, bus_pkg::LS_D);

        // interrupt controller storage
        for (int id = 0; id < bus_pkg::PLIC_SOURCES; id++) begin
            bus_write(bus_pkg::PLIC_BASE + 64'(4 * id), bus_pkg::LS_W, {$urandom, $urandom});
            bus_read(bus_pkg::PLIC_BASE + 64'(4 * id), bus_pkg::LS_W);
        end
        for (int c = 0; c < 2; c++) begin
            wd = {$urandom, $urandom};
            bus_write(bus_pkg::PLIC_ENABLE + c * bus_pkg::ENABLE_CTX_STRIDE, bus_pkg::LS_W, wd);
            bus_read(bus_pkg::PLIC_ENABLE + c * bus_pkg::ENABLE_CTX_STRIDE, bus_pkg::LS_W);
            wd = {$urandom, $urandom};
            bus_write(bus_pkg::PLIC_THRESHOLD + c * bus_pkg::CTX_STRIDE, bus_pkg::LS_W, wd);
            bus_read(bus_pkg::PLIC_THRESHOLD + c * bus_pkg::CTX_STRIDE, bus_pkg::LS_W);
        end

        // claim flow for context 0 then context 1
        for (int c = 0; c < 2; c++) begin
            bus_write(bus_pkg::PLIC_ENABLE, bus_pkg::LS_W,
                      (c == 0) ? (64'h1 << bus_pkg::IRQ_ID) : 64'h0);
            bus_write(bus_pkg::PLIC_ENABLE + bus_pkg::ENABLE_CTX_STRIDE, bus_pkg::LS_W,
                      (c == 1) ? (64'h1 << bus_pkg::IRQ_ID) : 64'h0);
            pulse_irq();
            check_irq_lines();
            bus_read(bus_pkg::PLIC_CLAIM + c * bus_pkg::CTX_STRIDE, bus_pkg::LS_W);
            check_irq_lines();
            bus_read(bus_pkg::PLIC_CLAIM + c * bus_pkg::CTX_STRIDE, bus_pkg::LS_W);
        end

        // unmapped address
        bus_read(UNMAPPED_ADDR, bus_pkg::LS_W);
        bus_write(UNMAPPED_ADDR, bus_pkg::LS_W, {$urandom, $urandom});

        @(negedge clock_slow);
        if (exp_q.size() != 0) begin
            fail_run($sformatf("%0d reads were never compared", exp_q.size()));
        end
        if (err_count == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire
